//--- all.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/address_stage.sv
verilog/memory_access_stage.sv
verilog/data_memory.sv
verilog/control_registers.sv
verilog/writeback_stage.sv
verilog/lsu_top.sv
sim/lsu_tb.sv

//--- sim/lsu_tb.sv
// Self-checking testbench for lsu_top.
// Uses data memory lines 0 to 7 only, which are filled before any load.
// Expectations are built when an instruction is driven and shifted along
// with it, so the checks line up with the I/O pulse and the writeback cycle.
// The I/O device answers with a value made from the address.
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_tb
	import lsu_pkg::*;
	;

	localparam logic [31:0] core_id_value = 32'h000000c5;
	localparam int n_fill = 8;
	localparam int n_scalar = 60;
	localparam int n_block = 20;
	localparam int n_unaligned = 12;
	localparam int n_io = 8;
	localparam int n_cr_idx = 6;
	localparam int n_squash = 6;
	localparam int n_drain = 4;
	localparam int total_issued = n_fill + 2 * n_scalar + 2 * n_block + 2 * n_unaligned
		+ 3 * n_io + 2 * n_cr_idx + 4 + 4 * n_squash + n_drain;
	localparam int cycle_limit = total_issued * 3 / 2 + 50;

	typedef struct packed
	{
		logic scalar_en;
		logic vector_en;
		logic fault;
		logic [4:0] wreg;
		logic [`LSU_LINE_BITS-1:0] value;
		logic [`LSU_LANES-1:0] mask;
		logic io_read;
		logic io_write;
		logic [15:0] io_addr;
		logic [31:0] io_data;
	} expect_t;

	logic clk;
	logic reset;
	logic squash;
	logic [31:0] op_instruction;
	logic [31:0] op_base;
	logic [31:0] op_offset;
	logic [`LSU_LINE_BITS-1:0] op_store_value;
	logic [`LSU_LANES-1:0] op_mask;
	logic [15:0] io_address;
	logic io_write_en;
	logic io_read_en;
	logic [31:0] io_write_data;
	logic [31:0] io_read_data;
	logic wb_scalar_en;
	logic wb_vector_en;
	logic [4:0] wb_reg;
	logic [`LSU_LINE_BITS-1:0] wb_value;
	logic [`LSU_LANES-1:0] wb_mask;
	logic wb_fault;

	logic [7:0] ref_mem [0:127];    // Lines 0 to 7 with byte 0 as the MSB byte
	logic [31:0] cr_model [1:3];
	logic [31:0] rng_state = 32'd37211;
	logic kill_pending;             // Squash owed to the previous instruction
	expect_t exp_next;
	expect_t exp_ac;
	expect_t exp_ma;
	expect_t exp_wb;
	int cycle_count = 0;

	lsu_top #(.core_id(core_id_value)) dut
		(
		.clk(clk),
		.reset(reset),
		.squash(squash),
		.op_instruction(op_instruction),
		.op_base(op_base),
		.op_offset(op_offset),
		.op_store_value(op_store_value),
		.op_mask(op_mask),
		.io_address(io_address),
		.io_write_en(io_write_en),
		.io_read_en(io_read_en),
		.io_write_data(io_write_data),
		.io_read_data(io_read_data),
		.wb_scalar_en(wb_scalar_en),
		.wb_vector_en(wb_vector_en),
		.wb_reg(wb_reg),
		.wb_value(wb_value),
		.wb_mask(wb_mask),
		.wb_fault(wb_fault)
		);

	function automatic logic [31:0] device_value(input logic [15:0] a);
		return {a ^ 16'hc3a5, ~a};
	endfunction

	assign io_read_data = device_value(io_address);    // I/O device model

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [127:0] rand128();
		return {next_rand(), next_rand(), next_rand(), next_rand()};
	endfunction

	function automatic logic [31:0] encode(input logic load, input mem_op_t op,
		input logic [4:0] wreg, input logic [4:0] cr);
		return {2'b10, load, op, 15'd0, wreg, cr};
	endfunction

	// Random address in lines 0 to 7 aligned for the access size
	function automatic logic [31:0] random_addr(input mem_op_t op);
		logic [31:0] a;
		a = next_rand() & 32'h7f;
		case (op)
			mem_b, mem_bx: ;
			mem_s, mem_sx: a[0] = 1'b0;
			mem_l, mem_control_reg: a[1:0] = 2'b00;
			default: a[3:0] = 4'h0;
		endcase
		return a;
	endfunction

	function automatic logic [127:0] ref_line(input logic [6:0] base);
		logic [127:0] v;
		for (int k = 0; k < 16; k++)
			v[(15 - k) * 8 +: 8] = ref_mem[base + k];
		return v;
	endfunction

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic fail_value(input string what);
		$display("FAILED at %0t ns: %s", $time, what);
		abort_run();
	endtask

	// Expected result of one instruction with the models updated in order
	task automatic predict(input logic [31:0] instr, input logic [31:0] addr,
		input logic [127:0] value, input logic [3:0] mask, input logic kill,
		output expect_t e);
		mem_op_t op;
		logic load;
		logic bad;
		logic [31:0] lane0;
		logic [31:0] field;
		logic [6:0] a;
		logic [6:0] line;
		logic [4:0] idx;
		int n;
		e = '0;
		op = mem_op_t'(instr[28:25]);
		load = instr[29];
		lane0 = value[127:96];
		a = addr[6:0];
		line = {addr[6:4], 4'h0};
		idx = instr[4:0];
		if (instr[31:30] != 2'b10 || kill)
			return;
		case (op)
			mem_b, mem_bx: bad = 1'b0;
			mem_s, mem_sx: bad = addr[0];
			mem_l, mem_control_reg: bad = addr[1:0] != 2'b00;
			default: bad = addr[3:0] != 4'h0;
		endcase
		if (addr[31:16] == 16'hffff && op != mem_l && op != mem_control_reg)
			bad = 1'b1;     // Only words reach the I/O port
		e.fault = bad;
		e.wreg = instr[9:5];
		e.mask = mask;
		if (bad)
			return;
		if (op == mem_control_reg)
		begin
			e.scalar_en = load;
			if (idx == 0)
				e.value = {core_id_value, 96'd0};
			else if (idx <= 3)
				e.value = {cr_model[idx], 96'd0};
			if (!load && idx >= 1 && idx <= 3)
				cr_model[idx] = lane0;
		end
		else if (addr[31:16] == 16'hffff)
		begin
			e.io_addr = addr[15:0];
			e.io_read = load;
			e.io_write = !load;
			e.io_data = lane0;
			e.scalar_en = load;
			e.value = {device_value(addr[15:0]), 96'd0};
		end
		else if (op != mem_b && op != mem_bx && op != mem_s && op != mem_sx && op != mem_l)
		begin
			if (mask == 4'b0000)
				return;
			e.vector_en = load;
			e.value = ref_line(line);
			for (int w = 0; w < 4; w++)
			begin
				for (int j = 0; j < 4 && !load && mask[w]; j++)
					ref_mem[line + w * 4 + j] = value[(15 - (w * 4 + j)) * 8 +: 8];
			end
		end
		else
		begin
			n = (op == mem_b || op == mem_bx) ? 1 : (op == mem_l) ? 4 : 2;
			field = 32'd0;
			for (int j = 0; j < n; j++)
			begin
				if (load)
					field = {field[23:0], ref_mem[a + j]};
				else
					ref_mem[a + j] = lane0[(n - 1 - j) * 8 +: 8];
			end
			if (op == mem_bx)
				field = {{24{field[7]}}, field[7:0]};
			if (op == mem_sx)
				field = {{16{field[15]}}, field[15:0]};
			e.scalar_en = load;
			e.value = {field, 96'd0};
		end
	endtask

	// One instruction per edge; kill squashes it on the following edge
	task automatic drive(input logic [31:0] instr, input logic [31:0] addr,
		input logic [127:0] value, input logic [3:0] mask, input logic kill);
		logic [31:0] base;
		expect_t e;
		base = next_rand();
		predict(instr, addr, value, mask, kill, e);
		@(posedge clk);
		op_instruction <= instr;
		op_base <= base;
		op_offset <= addr - base;   // Sum wraps back to addr
		op_store_value <= value;
		op_mask <= mask;
		squash <= kill_pending;
		exp_next <= e;
		kill_pending = kill;
	endtask

	task automatic fill_memory();
		for (int l = 0; l < n_fill; l++)
			drive(encode(1'b0, mem_block, 5'd0, 5'd0), l * 16, rand128(), 4'b1111, 1'b0);
	endtask

	task automatic scalar_test();
		mem_op_t st_op;
		mem_op_t ld_op;
		logic [31:0] addr;
		logic [31:0] laddr;
		for (int i = 0; i < n_scalar; i++)
		begin
			st_op = mem_op_t'((i % 3) * 2);     // b, s, l
			ld_op = mem_op_t'(i % 5);           // b, bx, s, sx, l
			addr = random_addr(st_op);
			laddr = random_addr(ld_op);
			laddr[6:4] = addr[6:4];             // Same line and often the same bytes
			drive(encode(1'b0, st_op, 5'd0, 5'd0), addr, rand128(), 4'b0000, 1'b0);
			drive(encode(1'b1, ld_op, 5'(i), 5'd0), laddr, 128'd0, 4'b0000, 1'b0);
		end
	endtask

	task automatic block_test();
		logic [31:0] line;
		logic [31:0] m;
		for (int i = 0; i < n_block; i++)
		begin
			line = random_addr(mem_block);
			m = next_rand();
			drive(encode(1'b0, mem_block, 5'd0, 5'd0), line, rand128(), m[3:0], 1'b0);
			drive(encode(1'b1, mem_block, 5'(i), 5'd0), line, 128'd0, m[7:4], 1'b0);
		end
	endtask

	task automatic unaligned_test();
		mem_op_t op;
		logic [31:0] r;
		logic [31:0] line;
		logic [31:0] a;
		for (int i = 0; i < n_unaligned; i++)
		begin
			r = next_rand();
			line = {25'd0, r[2:0], 4'h0};
			a = line | {28'd0, r[7:4]};
			op = (i % 3 == 0) ? mem_s : (i % 3 == 1) ? mem_l : mem_block;
			if (op == mem_s)
				a[0] = 1'b1;
			else if (a[1:0] == 2'b00)
				a[1] = 1'b1;
			drive(encode(1'((i / 3) % 2), op, 5'(i), 5'd0), a, rand128(), 4'b1111, 1'b0);
			drive(encode(1'b1, mem_block, 5'd31, 5'd0), line, 128'd0, 4'b1111, 1'b0);
		end
	endtask

	task automatic io_test();
		logic [31:0] r;
		logic [31:0] a;
		for (int i = 0; i < n_io; i++)
		begin
			r = next_rand();
			a = {16'hffff, r[15:2], 2'b00};
			drive(encode(1'b0, mem_l, 5'd0, 5'd0), a, rand128(), 4'b0000, 1'b0);
			drive(encode(1'b1, mem_l, 5'(i), 5'd0), a, 128'd0, 4'b0000, 1'b0);
			drive(encode(1'(i % 2), (i % 2) ? mem_bx : mem_b, 5'(i), 5'd0),
				{a[31:2], r[17:16]}, rand128(), 4'b0000, 1'b0);
		end
	endtask

	// Index 0 goes last so the scratch readback sees any stray write
	task automatic cr_test();
		logic [4:0] idx;
		drive(encode(1'b1, mem_control_reg, 5'd1, cr_core_id), 32'd0, 128'd0, 4'b0, 1'b0);
		for (int i = 0; i < n_cr_idx; i++)
		begin
			idx = 5'((i + 1) % n_cr_idx);
			drive(encode(1'b0, mem_control_reg, 5'd0, idx), 32'd0, rand128(), 4'b0, 1'b0);
			drive(encode(1'b1, mem_control_reg, idx + 5'd2, idx), 32'd0, 128'd0,
				4'b0, 1'b0);
		end
		for (int i = 1; i <= 3; i++)
			drive(encode(1'b1, mem_control_reg, 5'(i + 10), 5'(i)), 32'd0, 128'd0,
				4'b0, 1'b0);
	endtask

	// Kept store, squashed store, kept load, squashed load on one word
	task automatic squash_test();
		logic [31:0] a;
		for (int i = 0; i < n_squash; i++)
		begin
			a = random_addr(mem_l);
			drive(encode(1'b0, mem_l, 5'd0, 5'd0), a, rand128(), 4'b0, 1'b0);
			drive(encode(1'b0, mem_l, 5'd0, 5'd0), a, rand128(), 4'b0, 1'b1);
			drive(encode(1'b1, mem_l, 5'(i), 5'd0), a, 128'd0, 4'b0, 1'b0);
			drive(encode(1'b1, mem_l, 5'(i + 8), 5'd0), a, 128'd0, 4'b0, 1'b1);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Expectations move with their instruction through the three stages
	always @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			exp_ac <= '0;
			exp_ma <= '0;
			exp_wb <= '0;
		end
		else
		begin
			exp_ac <= exp_next;
			exp_ma <= exp_ac;
			exp_wb <= exp_ma;
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	assert property (@(posedge clk) disable iff (reset) wb_scalar_en == exp_wb.scalar_en)
		else fail_value($sformatf("wb_scalar_en is %0b, expected %0b",
			$sampled(wb_scalar_en), $sampled(exp_wb.scalar_en)));
	assert property (@(posedge clk) disable iff (reset) wb_vector_en == exp_wb.vector_en)
		else fail_value($sformatf("wb_vector_en is %0b, expected %0b",
			$sampled(wb_vector_en), $sampled(exp_wb.vector_en)));
	assert property (@(posedge clk) disable iff (reset) wb_fault == exp_wb.fault)
		else fail_value($sformatf("wb_fault is %0b, expected %0b",
			$sampled(wb_fault), $sampled(exp_wb.fault)));
	assert property (@(posedge clk) disable iff (reset)
		(exp_wb.scalar_en || exp_wb.vector_en) |-> wb_reg == exp_wb.wreg)
		else fail_value($sformatf("wb_reg is %0d, expected %0d",
			$sampled(wb_reg), $sampled(exp_wb.wreg)));
	assert property (@(posedge clk) disable iff (reset)
		(exp_wb.scalar_en || exp_wb.vector_en) |-> wb_value == exp_wb.value)
		else fail_value($sformatf("wb_value is %h, expected %h",
			$sampled(wb_value), $sampled(exp_wb.value)));
	assert property (@(posedge clk) disable iff (reset)
		exp_wb.vector_en |-> wb_mask == exp_wb.mask)
		else fail_value($sformatf("wb_mask is %b, expected %b",
			$sampled(wb_mask), $sampled(exp_wb.mask)));
	assert property (@(posedge clk) disable iff (reset)
		io_read_en == exp_ac.io_read && io_write_en == exp_ac.io_write)
		else fail_value($sformatf("io_read_en %0b io_write_en %0b, expected %0b %0b",
			$sampled(io_read_en), $sampled(io_write_en),
			$sampled(exp_ac.io_read), $sampled(exp_ac.io_write)));
	assert property (@(posedge clk) disable iff (reset)
		(exp_ac.io_read || exp_ac.io_write) |-> io_address == exp_ac.io_addr)
		else fail_value($sformatf("io_address is %h, expected %h",
			$sampled(io_address), $sampled(exp_ac.io_addr)));
	assert property (@(posedge clk) disable iff (reset)
		exp_ac.io_write |-> io_write_data == exp_ac.io_data)
		else fail_value($sformatf("io_write_data is %h, expected %h",
			$sampled(io_write_data), $sampled(exp_ac.io_data)));

	initial
	begin
		reset = 1'b1;
		squash = 1'b0;
		op_instruction = `LSU_NOP;
		op_base = 32'd0;
		op_offset = 32'd0;
		op_store_value = '0;
		op_mask = '0;
		kill_pending = 1'b0;
		exp_next = '0;
		for (int i = 1; i <= 3; i++)
			cr_model[i] = 32'd0;    // Scratch registers reset to zero
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		fill_memory();
		scalar_test();
		block_test();
		unaligned_test();
		io_test();
		cr_test();
		squash_test();
		for (int i = 0; i < n_drain; i++)
			drive(`LSU_NOP, 32'd0, 128'd0, 4'b0, 1'b0);
		@(posedge clk);     // Last writeback check
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- verilog/lsu_top.sv
// Load/store pipeline top: address, memory access and writeback stages.
// One instruction per clock, no back-pressure; writeback outputs appear two
// edges after op_ is sampled and are held for one cycle.
// io_read_data must be valid on the edge that ends io_read_en.
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_top
	import lsu_pkg::*;
	#(
	parameter logic [31:0] core_id = `LSU_CORE_ID
	)
	(
	input clk,
	input reset,
	input squash,
	input [31:0] op_instruction,
	input [31:0] op_base,
	input [31:0] op_offset,
	input [`LSU_LINE_BITS-1:0] op_store_value,
	input [`LSU_LANES-1:0] op_mask,
	output logic [15:0] io_address,
	output logic io_write_en,
	output logic io_read_en,
	output logic [31:0] io_write_data,
	input [31:0] io_read_data,
	output logic wb_scalar_en,
	output logic wb_vector_en,
	output logic [4:0] wb_reg,
	output logic [`LSU_LINE_BITS-1:0] wb_value,
	output logic [`LSU_LANES-1:0] wb_mask,
	output logic wb_fault
	);

	logic [31:0] ac_instruction;
	logic [31:0] ac_addr;
	logic [`LSU_LINE_BITS-1:0] ac_store_value;
	logic [`LSU_LANES-1:0] ac_mask;

	logic [$clog2(`LSU_MEM_LINES)-1:0] mem_addr;
	logic mem_load;
	logic mem_store;
	logic [`LSU_LINE_BYTES-1:0] mem_store_mask;
	logic [`LSU_LINE_BITS-1:0] mem_store_data;
	logic [`LSU_LINE_BITS-1:0] mem_read_data;

	cr_index_t cr_index;
	logic cr_write_en;
	logic [31:0] cr_write_value;
	logic [31:0] cr_read_value;

	logic [31:0] ma_instruction;
	logic [3:0] ma_addr_low;
	logic ma_fault;
	logic ma_is_io;
	logic [31:0] ma_io_response;
	logic [31:0] ma_cr_value;
	logic [`LSU_LANES-1:0] ma_mask;
	logic [4:0] ma_writeback_reg;

	address_stage u_address_stage(.*);

	memory_access_stage u_memory_access_stage(.*);

	data_memory u_data_memory(.*);

	control_registers #(.core_id(core_id)) u_control_registers(.*);

	writeback_stage u_writeback_stage(.*);

endmodule

//--- verilog/writeback_stage.sv
// Writeback stage: picks the load source, extracts and extends the field.
// Scalar results go in lane 0 (bits 127:96) with the other lanes zero.
// A block load with an all-zero mask and every store give no writeback.
`timescale 1ns/1ns
`include "lsu_defines.svh"

module writeback_stage
	import lsu_pkg::*;
	(
	input clk,
	input reset,
	input [31:0] ma_instruction,
	input [3:0] ma_addr_low,
	input ma_fault,
	input ma_is_io,
	input [31:0] ma_io_response,
	input [31:0] ma_cr_value,
	input [`LSU_LANES-1:0] ma_mask,
	input [4:0] ma_writeback_reg,
	input [`LSU_LINE_BITS-1:0] mem_read_data,
	output logic wb_scalar_en,
	output logic wb_vector_en,
	output logic [4:0] wb_reg,
	output logic [`LSU_LINE_BITS-1:0] wb_value,
	output logic [`LSU_LANES-1:0] wb_mask,
	output logic wb_fault
	);

	mem_op_t op;
	logic is_load;
	logic is_block;
	logic [31:0] mem_word;
	logic [31:0] src_word;
	logic [7:0] byte_field;
	logic [15:0] half_field;
	logic [31:0] scalar_value;

	assign op = mem_op_t'(ma_instruction[28:25]);
	assign is_load = ma_instruction[31:30] == 2'b10 && ma_instruction[29] && !ma_fault;

	// Word 0 is the most significant word of the line
	assign mem_word = mem_read_data[(3 - ma_addr_low[3:2]) * 32 +: 32];

	always_comb
	begin
		if (op == mem_control_reg)
			src_word = ma_cr_value;
		else if (ma_is_io)
			src_word = ma_io_response;
		else
			src_word = mem_word;
	end

	assign byte_field = src_word[31 - ma_addr_low[1:0] * 8 -: 8];    // Byte 0 is the MSB
	assign half_field = ma_addr_low[1] ? src_word[15:0] : src_word[31:16];

	always_comb
	begin
		is_block = 1'b0;
		case (op)
			mem_b: scalar_value = {24'd0, byte_field};
			mem_bx: scalar_value = {{24{byte_field[7]}}, byte_field};
			mem_s: scalar_value = {16'd0, half_field};
			mem_sx: scalar_value = {{16{half_field[15]}}, half_field};
			mem_l, mem_control_reg: scalar_value = src_word;
			default:
			begin
				is_block = 1'b1;
				scalar_value = src_word;
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_scalar_en <= 1'b0;
			wb_vector_en <= 1'b0;
			wb_fault <= 1'b0;
		end
		else
		begin
			wb_scalar_en <= is_load && !is_block;
			wb_vector_en <= is_load && is_block && ma_mask != '0;
			wb_fault <= ma_fault;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_reg <= ma_writeback_reg;
		wb_mask <= ma_mask;
		if (is_block)
			wb_value <= mem_read_data;
		else
			wb_value <= {scalar_value, {(`LSU_LINE_BITS-32){1'b0}}};
	end

endmodule

//--- verilog/control_registers.sv
// Control register block: core id at index 0, three scratch registers.
// Reads are combinational; writes land on the clock edge.
// Writes to index 0 and to unused indices are dropped, unused indices read 0.
`timescale 1ns/1ns
`include "lsu_defines.svh"

module control_registers
	import lsu_pkg::*;
	#(
	parameter logic [31:0] core_id = `LSU_CORE_ID
	)
	(
	input clk,
	input reset,
	input cr_index_t cr_index,
	input cr_write_en,
	input [31:0] cr_write_value,
	output logic [31:0] cr_read_value
	);

	logic [31:0] scratch [3];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 3; i++)
				scratch[i] <= 32'd0;
		end
		else if (cr_write_en)
		begin
			case (cr_index)
				cr_scratch0: scratch[0] <= cr_write_value;
				cr_scratch1: scratch[1] <= cr_write_value;
				cr_scratch2: scratch[2] <= cr_write_value;
				default: ;      // Read-only or unused
			endcase
		end
	end

	always_comb
	begin
		case (cr_index)
			cr_core_id: cr_read_value = core_id;
			cr_scratch0: cr_read_value = scratch[0];
			cr_scratch1: cr_read_value = scratch[1];
			cr_scratch2: cr_read_value = scratch[2];
			default: cr_read_value = 32'd0;
		endcase
	end

endmodule

//--- verilog/data_memory.sv
// Line-wide data memory standing in for the data cache; always hits.
// Write and read share the edge, and a read in the same cycle as a write
// to the same line returns the old contents.
// Contents are undefined after power-up and are not touched by reset.
// Mask bit b enables data bits b*8+7:b*8.
`timescale 1ns/1ns
`include "lsu_defines.svh"

module data_memory
	(
	input clk,
	input [$clog2(`LSU_MEM_LINES)-1:0] mem_addr,
	input mem_load,
	input mem_store,
	input [`LSU_LINE_BYTES-1:0] mem_store_mask,
	input [`LSU_LINE_BITS-1:0] mem_store_data,
	output logic [`LSU_LINE_BITS-1:0] mem_read_data
	);

	logic [`LSU_LINE_BITS-1:0] lines [`LSU_MEM_LINES];

	always_ff @(posedge clk)
	begin
		if (mem_store)
		begin
			for (int b = 0; b < `LSU_LINE_BYTES; b++)
			begin
				if (mem_store_mask[b])
					lines[mem_addr][b*8 +: 8] <= mem_store_data[b*8 +: 8];
			end
		end
	end

	// Holds its last value when no load is issued
	always_ff @(posedge clk)
	begin
		if (mem_load)
			mem_read_data <= lines[mem_addr];
	end

endmodule

//--- verilog/memory_access_stage.sv
// Memory access stage: alignment check, store placement and issue.
// Memory, I/O and control-register strobes are combinational from the
// address stage registers and take effect on the next edge.
// Store mask bit b enables data bits b*8+7:b*8; line byte 0 is the MSB byte,
// so address byte j of a line maps to mask bit 15-j (big-endian).
// Only word accesses may touch the I/O region; others fault.
// squash cancels the instruction currently in the address stage registers.
`timescale 1ns/1ns
`include "lsu_defines.svh"

module memory_access_stage
	import lsu_pkg::*;
	(
	input clk,
	input reset,
	input squash,
	input [31:0] ac_instruction,
	input [31:0] ac_addr,
	input [`LSU_LINE_BITS-1:0] ac_store_value,
	input [`LSU_LANES-1:0] ac_mask,
	output logic [$clog2(`LSU_MEM_LINES)-1:0] mem_addr,
	output logic mem_load,
	output logic mem_store,
	output logic [`LSU_LINE_BYTES-1:0] mem_store_mask,
	output logic [`LSU_LINE_BITS-1:0] mem_store_data,
	output logic [15:0] io_address,
	output logic io_write_en,
	output logic io_read_en,
	output logic [31:0] io_write_data,
	input [31:0] io_read_data,
	output cr_index_t cr_index,
	output logic cr_write_en,
	output logic [31:0] cr_write_value,
	input [31:0] cr_read_value,
	output logic [31:0] ma_instruction,
	output logic [3:0] ma_addr_low,
	output logic ma_fault,
	output logic ma_is_io,
	output logic [31:0] ma_io_response,
	output logic [31:0] ma_cr_value,
	output logic [`LSU_LANES-1:0] ma_mask,
	output logic [4:0] ma_writeback_reg
	);

	localparam int line_addr_bits = $clog2(`LSU_MEM_LINES);

	mem_op_t op;
	logic is_mem;
	logic is_load;
	logic is_cr;
	logic is_block;
	logic is_io;
	logic unaligned;
	logic bad_io;
	logic fault;
	logic access_en;
	logic [31:0] lane0_value;
	logic [31:0] placed_word;
	logic [3:0] byte_pos_mask;              // Bit p selects bits p*8+7:p*8 of a word
	logic [`LSU_LANES-1:0] word_pos_mask;   // Bit p selects bits p*32+31:p*32 of the line

	assign op = mem_op_t'(ac_instruction[28:25]);
	assign is_mem = ac_instruction[31:30] == 2'b10;
	assign is_load = ac_instruction[29];
	assign is_cr = op == mem_control_reg;
	assign is_io = ac_addr[31:16] == `LSU_IO_PREFIX;
	assign lane0_value = ac_store_value[`LSU_LINE_BITS-1 -: 32];   // Lane 0 is the top lane

	// Per-opcode alignment rule and placement within a word
	always_comb
	begin
		is_block = 1'b0;
		unaligned = 1'b0;
		byte_pos_mask = 4'b1111;
		placed_word = lane0_value;
		case (op)
			mem_b, mem_bx:
			begin
				byte_pos_mask = 4'b1000 >> ac_addr[1:0];
				placed_word = {4{lane0_value[7:0]}};
			end
			mem_s, mem_sx:
			begin
				unaligned = ac_addr[0];
				byte_pos_mask = ac_addr[1] ? 4'b0011 : 4'b1100;
				placed_word = {2{lane0_value[15:0]}};
			end
			mem_l, mem_control_reg:
				unaligned = ac_addr[1:0] != 2'b00;
			default:    // Block, and any unknown code
			begin
				is_block = 1'b1;
				unaligned = ac_addr[3:0] != 4'b0000;
			end
		endcase
	end

	// Word i of the line sits at position 3-i
	always_comb
	begin
		for (int p = 0; p < `LSU_LANES; p++)
		begin
			if (is_block)
				word_pos_mask[p] = ac_mask[`LSU_LANES-1-p];
			else
				word_pos_mask[p] = ac_addr[3:2] == 2'(`LSU_LANES-1-p);
		end
	end

	always_comb
	begin
		for (int b = 0; b < `LSU_LINE_BYTES; b++)
			mem_store_mask[b] = word_pos_mask[b / 4] & byte_pos_mask[b % 4];
	end

	assign bad_io = is_io && !is_cr && op != mem_l;
	assign fault = is_mem && !squash && (unaligned || bad_io);
	// Empty block mask means nothing to do
	assign access_en = is_mem && !squash && !fault && !(is_block && ac_mask == '0);

	assign mem_addr = ac_addr[line_addr_bits+3:4];
	assign mem_store_data = is_block ? ac_store_value : {`LSU_LANES{placed_word}};
	assign mem_load = access_en && !is_cr && !is_io && is_load;
	assign mem_store = access_en && !is_cr && !is_io && !is_load;

	assign io_address = ac_addr[15:0];
	assign io_write_data = lane0_value;
	assign io_read_en = access_en && !is_cr && is_io && is_load;
	assign io_write_en = access_en && !is_cr && is_io && !is_load;

	assign cr_index = cr_index_t'(ac_instruction[4:0]);
	assign cr_write_value = lane0_value;
	assign cr_write_en = access_en && is_cr && !is_load;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ma_instruction <= `LSU_NOP;
			ma_fault <= 1'b0;
		end
		else
		begin
			ma_instruction <= squash ? `LSU_NOP : ac_instruction;
			ma_fault <= fault;
		end
	end

	always_ff @(posedge clk)
	begin
		ma_addr_low <= ac_addr[3:0];
		ma_is_io <= is_io && !is_cr;
		ma_io_response <= io_read_data;     // Same edge that ends io_read_en
		ma_cr_value <= cr_read_value;
		ma_mask <= ac_mask;
		ma_writeback_reg <= ac_instruction[9:5];
	end

endmodule

//--- verilog/address_stage.sv
// First stage of the load/store pipeline.
// Inputs are sampled every edge; there is no valid strobe and no stall.
// Anything not marked as a memory instruction (bits 31:30 == 10) becomes a NOP,
// so the later stages only see memory instructions or NOPs.
`timescale 1ns/1ns
`include "lsu_defines.svh"

module address_stage
	(
	input clk,
	input reset,
	input [31:0] op_instruction,
	input [31:0] op_base,
	input [31:0] op_offset,
	input [`LSU_LINE_BITS-1:0] op_store_value,
	input [`LSU_LANES-1:0] op_mask,
	output logic [31:0] ac_instruction,
	output logic [31:0] ac_addr,
	output logic [`LSU_LINE_BITS-1:0] ac_store_value,
	output logic [`LSU_LANES-1:0] ac_mask
	);

	logic is_mem;
	logic [31:0] effective_addr;

	assign is_mem = op_instruction[31:30] == 2'b10;
	assign effective_addr = op_base + op_offset;    // Wraps modulo 2^32

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			ac_instruction <= `LSU_NOP;
		else if (is_mem)
			ac_instruction <= op_instruction;
		else
			ac_instruction <= `LSU_NOP;
	end

	// Payload follows the instruction, meaningless under a NOP
	always_ff @(posedge clk)
	begin
		ac_addr <= effective_addr;
		ac_store_value <= op_store_value;
		ac_mask <= op_mask;
	end

endmodule

//--- verilog/lsu_pkg.sv
// Types for the load/store pipeline.
// Opcode codes not listed in mem_op_t decode as block accesses.

package lsu_pkg;

	// Instruction bits 28:25 of a memory instruction
	typedef enum logic [3:0]
	{
		mem_b = 4'd0,           // Byte, zero extended
		mem_bx = 4'd1,          // Byte, sign extended
		mem_s = 4'd2,           // Halfword, zero extended
		mem_sx = 4'd3,          // Halfword, sign extended
		mem_l = 4'd4,           // Word
		mem_control_reg = 4'd6,
		mem_block = 4'd7        // Masked vector line
	} mem_op_t;

	// Control register index, instruction bits 4:0
	typedef enum logic [4:0]
	{
		cr_core_id = 5'd0,
		cr_scratch0 = 5'd1,
		cr_scratch1 = 5'd2,
		cr_scratch2 = 5'd3
	} cr_index_t;

endpackage

//--- verilog/lsu_defines.svh
// Widths and constants shared by the load/store pipeline and its testbench.
// Lane count and line size are tied together: one block access is one line.
// Changing LSU_MEM_LINES changes how many address bits select a line.
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Lanes per vector, also words per line
`define LSU_LANES 4
`define LSU_LINE_BITS 128
`define LSU_LINE_BYTES 16

// Data memory depth in lines, higher address bits alias
`define LSU_MEM_LINES 64

`define LSU_NOP 32'h00000000

// Upper address half that selects the I/O port
`define LSU_IO_PREFIX 16'hffff

`define LSU_CORE_ID 32'h00000007

`endif
